// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/pipe_reg.sv
  - logic/fetch_stage.sv
  - logic/decoder.sv
  - logic/reg_file.sv
  - logic/hazard_unit.sv
  - logic/execute_stage.sv
  - logic/rv_core.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_rv_core.sv

// File: build.f
+incdir+dv
logic/rv_pkg.sv
logic/pipe_reg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/rv_core.sv
dv/tb_rv_core.sv

// File: dv/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// --------------------------------------------------
// instruction encoders
// --------------------------------------------------
function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, op_rtype};
endfunction

function automatic word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

// sw only, so funct3 is fixed
function automatic word_t enc_s(input reg_idx_t base, input reg_idx_t src,
                                input logic [11:0] imm);
    return {imm[11:5], src, base, 3'b010, imm[4:0], op_store};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

function automatic word_t enc_u(input reg_idx_t rd, input logic [19:0] upper);
    return {upper, rd, op_lui};
endfunction

// --------------------------------------------------
// program building blocks
// --------------------------------------------------
task automatic emit(input word_t word);
    imem[prog_len] = word;
    prog_len++;
endtask

task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

// lui + addi, upper part rounded for the sign-extended low half
task automatic load_const(input reg_idx_t rd, input word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    emit(enc_u(rd, upper[19:0]));
    emit(enc_i(op_itype, 3'b000, rd, rd, value[11:0]));
endtask

task automatic store_word(input reg_idx_t src, input logic [11:0] addr);
    emit(enc_s(5'd0, src, addr));
endtask

// jal to itself, then two nops for the fetch shadow
task automatic emit_halt();
    end_pc = word_t'(prog_len * 4);
    emit(enc_j(5'd0, 21'd0));
    emit(nop_instr);
    emit(nop_instr);
endtask

// --------------------------------------------------
// program loaders
// --------------------------------------------------
// one R-type result into x3, then stored right away
task automatic alu_step(input logic [6:0] f7, input logic [2:0] f3, input reg_idx_t rs1,
                        input reg_idx_t rs2, input word_t result, input int k);
    emit(enc_r(f7, f3, 5'd3, rs1, rs2));
    store_word(5'd3, 12'h100 + 12'(4 * k));
    expect_store(32'h100 + 4 * k, result);
endtask

task automatic load_alu_program(input word_t a, input word_t b);
    word_t r;
    load_const(5'd1, a);
    load_const(5'd2, b);
    // each step reads the x3 of the step before, two slots back
    r = a + b;
    alu_step(7'h00, 3'b000, 5'd1, 5'd2, r, 0);
    r = b - r;
    alu_step(7'h20, 3'b000, 5'd2, 5'd3, r, 1);
    r = r & b;
    alu_step(7'h00, 3'b111, 5'd3, 5'd2, r, 2);
    r = r | a;
    alu_step(7'h00, 3'b110, 5'd3, 5'd1, r, 3);
    r = r ^ b;
    alu_step(7'h00, 3'b100, 5'd3, 5'd2, r, 4);
    r = r << a[4:0];
    alu_step(7'h00, 3'b001, 5'd3, 5'd1, r, 5);
    r = r >> b[4:0];
    alu_step(7'h00, 3'b101, 5'd3, 5'd2, r, 6);
    r = ($signed(r) < $signed(a)) ? 32'd1 : 32'd0;
    alu_step(7'h00, 3'b010, 5'd3, 5'd1, r, 7);
    emit_halt();
endtask

// dependent addi directly behind the load
task automatic load_load_use_program(input word_t value);
    load_const(5'd1, value);
    store_word(5'd1, 12'h040);
    emit(enc_i(op_load, 3'b010, 5'd5, 5'd0, 12'h040));
    emit(enc_i(op_itype, 3'b000, 5'd6, 5'd5, 12'd123));
    store_word(5'd6, 12'h044);
    expect_store(32'h40, value);
    expect_store(32'h44, value + 32'd123);
    emit_halt();
endtask

// branch over a fall-through store and a jal into the taken-path store
task automatic branch_case(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                           input int k, input bit take);
    emit(enc_b(f3, rs1, rs2, 13'd12));
    store_word(5'd10, 12'h200 + 12'(8 * k));
    emit(enc_j(5'd0, 21'd8));
    store_word(5'd11, 12'h204 + 12'(8 * k));
    if (take) begin
        expect_store(32'h204 + 8 * k, 32'h7a);
    end else begin
        expect_store(32'h200 + 8 * k, 32'h0f);
    end
endtask

task automatic load_branch_program();
    // x1 = 5, x2 = -3, x3 = 5, markers in x10 and x11
    emit(enc_i(op_itype, 3'b000, 5'd10, 5'd0, 12'h00f));
    emit(enc_i(op_itype, 3'b000, 5'd11, 5'd0, 12'h07a));
    emit(enc_i(op_itype, 3'b000, 5'd1, 5'd0, 12'd5));
    emit(enc_i(op_itype, 3'b000, 5'd3, 5'd0, 12'd5));
    emit(enc_i(op_itype, 3'b000, 5'd2, 5'd0, 12'hffd));
    branch_case(3'b000, 5'd1, 5'd3, 0, 1'b1);
    branch_case(3'b000, 5'd1, 5'd2, 1, 1'b0);
    branch_case(3'b001, 5'd1, 5'd2, 2, 1'b1);
    branch_case(3'b001, 5'd1, 5'd3, 3, 1'b0);
    branch_case(3'b100, 5'd2, 5'd1, 4, 1'b1);
    branch_case(3'b100, 5'd1, 5'd2, 5, 1'b0);
    branch_case(3'b101, 5'd1, 5'd2, 6, 1'b1);
    branch_case(3'b101, 5'd2, 5'd1, 7, 1'b0);
    emit_halt();
endtask

task automatic load_jump_program();
    int    p;
    word_t tgt;
    emit(enc_i(op_itype, 3'b000, 5'd1, 5'd0, 12'h055));
    // jal x5, +8 over one store
    p = prog_len;
    emit(enc_j(5'd5, 21'd8));
    store_word(5'd1, 12'h300);
    store_word(5'd5, 12'h304);
    expect_store(32'h304, word_t'(p * 4 + 4));
    // jalr through an odd address, bit 0 has to drop
    p = prog_len;
    tgt = word_t'((p + 3) * 4 + 1);
    emit(enc_i(op_itype, 3'b000, 5'd7, 5'd0, tgt[11:0]));
    emit(enc_i(op_jalr, 3'b000, 5'd6, 5'd7, 12'd0));
    store_word(5'd1, 12'h308);
    store_word(5'd6, 12'h30c);
    expect_store(32'h30c, word_t'((p + 1) * 4 + 4));
    emit_halt();
endtask

task automatic load_x0_program();
    emit(enc_i(op_itype, 3'b000, 5'd0, 5'd0, 12'd55));
    // must read zero, not the discarded 55
    emit(enc_i(op_itype, 3'b000, 5'd1, 5'd0, 12'd7));
    store_word(5'd0, 12'h380);
    store_word(5'd1, 12'h384);
    emit(enc_u(5'd0, 20'h12345));
    store_word(5'd0, 12'h388);
    expect_store(32'h380, 32'd0);
    expect_store(32'h384, 32'd7);
    expect_store(32'h388, 32'd0);
    emit_halt();
endtask

`endif

// File: dv/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    localparam int reset_cycles = 10;
    localparam int drain_cycles = 8;
    localparam int slack_factor = 4;

    logic  clk;
    logic  reset;
    word_t pc;
    word_t instr;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    // memory models, word addressed
    word_t imem [0:255];
    word_t dmem [0:255];

    // program under construction and its expected stores
    int    prog_len;
    word_t end_pc;
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t log_addr [$];
    word_t log_data [$];

    integer seed = 33;
    int     errors;
    int     tests_run;
    int     cycle_count;
    int     limit_cycles;

    `include "tb_programs.svh"

    rv_core i_rv_core (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // memories, serviced on the falling edge
    // --------------------------------------------------
    // write first so a load one cycle behind a store sees it
    always @(negedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[9:2]] = dmem_wdata;
            log_addr.push_back(dmem_addr);
            log_data.push_back(dmem_wdata);
        end
        instr      <= imem[pc[9:2]];
        dmem_rdata <= dmem[dmem_addr[9:2]];
    end

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count > limit_cycles);
        $display("watchdog expired after %0d cycles, program never reached its end",
                 cycle_count);
        $display("errors: %0d, tests run: %0d", errors, tests_run);
        $display("test failed");
        $finish;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected address %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // store log against expectations, in order
    task automatic check_log(input string name);
        int n;
        n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
        if (log_addr.size() != exp_addr.size()) begin
            $display("%s: the core made %0d stores where %0d were expected",
                     name, log_addr.size(), exp_addr.size());
            errors++;
        end
        for (int i = 0; i < n; i++) begin
            check_addr($sformatf("%s store %0d", name, i), exp_addr[i], log_addr[i]);
            check_word($sformatf("%s store %0d", name, i), exp_data[i], log_data[i]);
        end
    endtask

    // --------------------------------------------------
    // run control
    // --------------------------------------------------
    // core held in reset while the next program is written
    task automatic hold_reset();
        limit_cycles += (reset_cycles + 2) * slack_factor;
        @(negedge clk);
        reset    = 1'b1;
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
        log_addr.delete();
        log_data.delete();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {16'(i), 16'(i)} ^ 32'hc3c3_5a5a;
        end
    endtask

    task automatic run_and_check(input string name);
        limit_cycles += (prog_len + drain_cycles) * slack_factor;
        repeat (reset_cycles) @(negedge clk);
        // first fetch out of reset, and nothing stored meanwhile
        check_addr({name, " reset pc"}, reset_pc, pc);
        if (log_addr.size() != 0) begin
            $display("%s: %0d stores happened while reset was held", name, log_addr.size());
            errors++;
        end
        reset = 1'b0;
        while (pc !== end_pc) begin
            @(negedge clk);
        end
        repeat (drain_cycles) @(negedge clk);
        check_log(name);
        tests_run++;
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_alu_forwarding();
        word_t a;
        word_t b;
        a = $random(seed);
        b = $random(seed);
        hold_reset();
        load_alu_program(a, b);
        run_and_check("alu forwarding");
    endtask

    task automatic test_load_use();
        word_t value;
        value = $random(seed);
        hold_reset();
        load_load_use_program(value);
        run_and_check("load use");
    endtask

    task automatic test_branches();
        hold_reset();
        load_branch_program();
        run_and_check("branches");
    endtask

    task automatic test_jumps();
        hold_reset();
        load_jump_program();
        run_and_check("jumps");
    endtask

    task automatic test_x0_reset();
        hold_reset();
        load_x0_program();
        run_and_check("x0 and reset");
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = nop_instr;
        dmem_rdata   = '0;
        errors       = 0;
        tests_run    = 0;
        cycle_count  = 0;
        limit_cycles = 0;
        prog_len     = 0;
        end_pc       = '0;

        test_alu_forwarding();
        test_load_use();
        test_branches();
        test_jumps();
        test_x0_reset();

        $display("errors: %0d, tests run: %0d", errors, tests_run);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: logic/decoder.sv
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
    input  word_t    instr,
    output ctrl_t    ctrl,
    output word_t    imm,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output logic     uses_rs1,
    output logic     uses_rs2
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // --------------------------------------------------
    // immediate formats
    // --------------------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // --------------------------------------------------
    // control generation
    // --------------------------------------------------
    always_comb begin
        ctrl     = '0;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        legal    = 1'b1;
        case (opcode)
            op_rtype: begin
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = alu_add;
                    10'b0100000_000: ctrl.alu_op = alu_sub;
                    10'b0000000_111: ctrl.alu_op = alu_and;
                    10'b0000000_110: ctrl.alu_op = alu_or;
                    10'b0000000_100: ctrl.alu_op = alu_xor;
                    10'b0000000_010: ctrl.alu_op = alu_slt;
                    10'b0000000_001: ctrl.alu_op = alu_sll;
                    10'b0000000_101: ctrl.alu_op = alu_srl;
                    default:         legal       = 1'b0;
                endcase
            end
            op_itype: begin
                uses_rs1       = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_i;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_add;
                    3'b111:  ctrl.alu_op = alu_and;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b010:  ctrl.alu_op = alu_slt;
                    // immediate shifts are not part of the subset
                    default: legal       = 1'b0;
                endcase
            end
            op_load: begin
                uses_rs1        = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                imm             = imm_i;
                legal           = (funct3 == 3'b010);
            end
            op_store: begin
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = imm_s;
                legal          = (funct3 == 3'b010);
            end
            op_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_cond = br_eq;
                    3'b001:  ctrl.br_cond = br_ne;
                    3'b100:  ctrl.br_cond = br_lt;
                    3'b101:  ctrl.br_cond = br_ge;
                    default: legal        = 1'b0;
                endcase
            end
            op_jal: begin
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_j;
            end
            op_jalr: begin
                uses_rs1       = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_i;
                legal          = (funct3 == 3'b000);
            end
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            default: legal = 1'b0;
        endcase

        // anything outside the subset turns into a bubble
        if (!legal) begin
            ctrl     = '0;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  id_ex_t   ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    mem_fwd,
    input  word_t    wb_fwd,
    output ex_mem_t  out,
    output logic     redirect,
    output word_t    redirect_pc
);

    localparam int shamt_w = $clog2(xlen);

    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_result;
    word_t link_pc;
    word_t jalr_target;
    logic  is_jump;
    logic  taken;

    // --------------------------------------------------
    // operand selection
    // --------------------------------------------------
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        word_t value;
        case (sel)
            fwd_from_mem: value = mem_val;
            fwd_from_wb:  value = wb_val;
            default:      value = reg_val;
        endcase
        return value;
    endfunction

    assign op_a    = fwd_mux(fwd_a, ex.rs1_data, mem_fwd, wb_fwd);
    assign rs2_val = fwd_mux(fwd_b, ex.rs2_data, mem_fwd, wb_fwd);
    assign op_b    = ex.ctrl.use_imm ? ex.imm : rs2_val;

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb begin
        case (ex.ctrl.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_sll:    alu_result = op_a << op_b[shamt_w-1:0];
            alu_srl:    alu_result = op_a >> op_b[shamt_w-1:0];
            // lui
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // --------------------------------------------------
    // branch and jump resolution
    // --------------------------------------------------
    // compare on forwarded registers, never the immediate
    always_comb begin
        case (ex.ctrl.br_cond)
            br_eq:   taken = (op_a == rs2_val);
            br_ne:   taken = (op_a != rs2_val);
            br_lt:   taken = ($signed(op_a) < $signed(rs2_val));
            br_ge:   taken = ($signed(op_a) >= $signed(rs2_val));
            default: taken = 1'b0;
        endcase
    end

    assign is_jump     = ex.ctrl.jal || ex.ctrl.jalr;
    assign link_pc     = ex.pc + word_t'(4);
    assign jalr_target = op_a + ex.imm;

    // fetch predicts not-taken, so any taken control flow redirects
    assign redirect    = taken || is_jump;
    assign redirect_pc = ex.ctrl.jalr ? {jalr_target[xlen-1:1], 1'b0} : ex.pc + ex.imm;

    // --------------------------------------------------
    // EX/MEM payload
    // --------------------------------------------------
    assign out.alu_result = is_jump ? link_pc : alu_result;
    assign out.store_data = rs2_val;
    assign out.rd         = ex.rd;
    assign out.mem_write  = ex.ctrl.mem_write;
    assign out.reg_write  = ex.ctrl.reg_write;
    assign out.mem_to_reg = ex.ctrl.mem_to_reg;

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t pc
);

    word_t pc_next;

    // static not-taken, so the only way off the sequential path is
    // a redirect out of execute
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + word_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  logic     uses_rs1,
    input  logic     uses_rs2,
    input  id_ex_t   ex,
    input  ex_mem_t  mem,
    input  mem_wb_t  wb,
    input  logic     redirect,
    output logic     stall,
    output logic     if_id_flush,
    output logic     id_ex_bubble,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    logic load_use;

    // --------------------------------------------------
    // stall and flush
    // --------------------------------------------------
    // load in EX whose result is read in ID
    assign load_use = ex.ctrl.mem_read && (ex.rd != '0) &&
                      ((uses_rs1 && (id_rs1 == ex.rd)) ||
                       (uses_rs2 && (id_rs2 == ex.rd)));

    // EX holds either a load or a jump, never both,
    // so stall and redirect do not collide
    assign stall        = load_use;
    assign if_id_flush  = redirect;
    assign id_ex_bubble = load_use || redirect;

    // --------------------------------------------------
    // forwarding selects
    // --------------------------------------------------
    // youngest producer wins
    function automatic fwd_sel_e pick_source(input reg_idx_t src, input ex_mem_t m,
                                             input mem_wb_t w);
        fwd_sel_e sel;
        if (m.reg_write && (m.rd != '0) && (m.rd == src)) begin
            sel = fwd_from_mem;
        end else if (w.reg_write && (w.rd != '0) && (w.rd == src)) begin
            sel = fwd_from_wb;
        end else begin
            sel = fwd_reg;
        end
        return sel;
    endfunction

    assign fwd_a = pick_source(ex.rs1, mem, wb);
    assign fwd_b = pick_source(ex.rs2, mem, wb);

endmodule

// File: logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t bubble    = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush beats enable, so a stalled slot can still be killed
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= bubble;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  mem_wb_t  wb,
    output word_t    wb_data
);

    // x0 has no storage
    word_t regs [1:31];
    logic  wr_en;

    // writeback select, also the MEM/WB forwarding source
    assign wb_data = wb.mem_to_reg ? wb.load_data : wb.alu_result;
    assign wr_en   = wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb_data;
        end
    end

    // write-through, so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (wr_en && (wb.rd == idx)) begin
            value = wb_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t pc,
    input  word_t instr,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    // hazard and redirect
    logic     stall;
    logic     if_id_flush;
    logic     id_ex_bubble;
    logic     redirect;
    word_t    redirect_pc;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    // decode side
    ctrl_t    id_ctrl;
    word_t    id_imm;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    reg_idx_t id_rd;
    logic     id_uses_rs1;
    logic     id_uses_rs2;
    word_t    id_rs1_data;
    word_t    id_rs2_data;
    word_t    wb_data;

    // stage payloads, d into and q out of each register
    if_id_t   if_id_d;
    if_id_t   if_id_q;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;

    // --------------------------------------------------
    // fetch
    // --------------------------------------------------
    fetch_stage i_fetch_stage (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    assign if_id_d = '{pc: pc, instr: instr};

    pipe_reg #(.payload_t(if_id_t), .bubble(if_id_bubble)) i_if_id (
        .clk   (clk),
        .reset (reset),
        .en    (!stall),
        .flush (if_id_flush),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    decoder i_decoder (
        .instr    (if_id_q.instr),
        .ctrl     (id_ctrl),
        .imm      (id_imm),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rd       (id_rd),
        .uses_rs1 (id_uses_rs1),
        .uses_rs2 (id_uses_rs2)
    );

    // write side fed straight from MEM/WB
    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data),
        .wb       (mem_wb_q),
        .wb_data  (wb_data)
    );

    hazard_unit i_hazard_unit (
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .uses_rs1     (id_uses_rs1),
        .uses_rs2     (id_uses_rs2),
        .ex           (id_ex_q),
        .mem          (ex_mem_q),
        .wb           (mem_wb_q),
        .redirect     (redirect),
        .stall        (stall),
        .if_id_flush  (if_id_flush),
        .id_ex_bubble (id_ex_bubble),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

    assign id_ex_d = '{
        pc:       if_id_q.pc,
        ctrl:     id_ctrl,
        rs1:      id_rs1,
        rs2:      id_rs2,
        rd:       id_rd,
        imm:      id_imm,
        rs1_data: id_rs1_data,
        rs2_data: id_rs2_data
    };

    // bubble on load-use or redirect
    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk   (clk),
        .reset (reset),
        .en    (1'b1),
        .flush (id_ex_bubble),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // --------------------------------------------------
    // execute
    // --------------------------------------------------
    execute_stage i_execute_stage (
        .ex          (id_ex_q),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .mem_fwd     (ex_mem_q.alu_result),
        .wb_fwd      (wb_data),
        .out         (ex_mem_d),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk   (clk),
        .reset (reset),
        .en    (1'b1),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // --------------------------------------------------
    // memory and writeback
    // --------------------------------------------------
    // write strobe lasts only the store's MEM cycle
    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_we    = ex_mem_q.mem_write;

    assign mem_wb_d = '{
        alu_result: ex_mem_q.alu_result,
        load_data:  dmem_rdata,
        rd:         ex_mem_q.rd,
        reg_write:  ex_mem_q.reg_write,
        mem_to_reg: ex_mem_q.mem_to_reg
    };

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk   (clk),
        .reset (reset),
        .en    (1'b1),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    // --------------------------------------------------
    // widths and fixed values
    // --------------------------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // first fetch address out of reset
    localparam word_t reset_pc  = '0;
    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;

    // --------------------------------------------------
    // control encodings
    // --------------------------------------------------
    // add at zero so an all-zero ctrl is a harmless bubble
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge
    } br_cond_e;

    // operand source picked in execute
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
        br_cond_e br_cond;
        logic     jal;
        logic     jalr;
    } ctrl_t;

    // --------------------------------------------------
    // stage payloads
    // --------------------------------------------------
    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        word_t    rs1_data;
        word_t    rs2_data;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_to_reg;
    } mem_wb_t;

    // flushed fetch slot carries a real nop
    localparam if_id_t if_id_bubble = '{pc: reset_pc, instr: nop_instr};

endpackage
